/* build.f */
+incdir+.
hdl/cfg_pkg.sv
hdl/cfgreg.sv
hdl/core_rst_seq.sv
hdl/ddr_remap.sv
hdl/cfg_subsys.sv
tb/tb_cfg_subsys.sv

/* Bender.yml */
package:
  name: cfg_subsys

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - hdl/cfg_pkg.sv
      - hdl/cfgreg.sv
      - hdl/core_rst_seq.sv
      - hdl/ddr_remap.sv
      - hdl/cfg_subsys.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb/tb_cfg_subsys.sv

/* tb/tb_cfg_subsys.sv */
`include "cfg_defs.svh"

module tb_cfg_subsys;

    import cfg_pkg::*;

    localparam int APB_TMO = 16;
    localparam int RST_TMO = 4 * (`CORE_RST_HOLD + 1);

    logic     clk;
    logic     rstn;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     core_req_valid;
    mem_req_t core_req;
    logic     core_rst_n;
    xaddr_t   boot_addr;
    logic     ddr_req_valid;
    mem_req_t ddr_req;
    logic     addr_err;

    integer   seed = 32'h1d5a_d7e0;
    int       err_cnt = 0;
    int       tmo_cnt = 0;
    xaddr_t   cur_boot;
    xaddr_t   cur_offset;
    mem_req_t stim_q[$];  // requests for the next call of drive_requests

    cfg_subsys UUT (
        .clk            (clk),
        .rstn           (rstn),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_rst_n     (core_rst_n),
        .boot_addr      (boot_addr),
        .ddr_req_valid  (ddr_req_valid),
        .ddr_req        (ddr_req),
        .addr_err       (addr_err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_data(input string name, input xdata_t got, input xdata_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input xaddr_t got, input xaddr_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Fail at %0t: %s is we=%b addr=%h wdata=%h, expected we=%b addr=%h wdata=%h",
                     $time, name, got.we, got.addr, got.wdata, exp.we, exp.addr, exp.wdata);
        end
    endtask

    function automatic mem_req_t mem_request(input logic we, input xaddr_t addr,
                                             input xdata_t wdata);
        mem_req_t req;
        req.we    = we;
        req.addr  = addr;
        req.wdata = wdata;
        return req;
    endfunction

    // setup phase, then access phase until pready, then back to idle
    task automatic apb_transfer(input logic write, input xaddr_t addr, input xdata_t wdata,
                                output xdata_t rdata);
        apb_req_t req;
        int       n;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = write;
        req.paddr   = addr;
        req.pwdata  = write ? wdata : '0;
        @(posedge clk);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge clk);
        apb_req <= req;
        n = 0;
        @(negedge clk);
        while (apb_rsp.pready !== 1'b1 && n < APB_TMO) begin
            @(negedge clk);
            n++;
        end
        if (apb_rsp.pready !== 1'b1) begin
            tmo_cnt++;
            $display("timeout: APB transfer to %h never saw pready", addr);
        end
        rdata = apb_rsp.prdata;
        check_bit("pslverr", apb_rsp.pslverr, 1'b0);
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_write(input xaddr_t addr, input xdata_t wdata);
        xdata_t unused;
        apb_transfer(1'b1, addr, wdata, unused);
    endtask

    task automatic apb_read(input xaddr_t addr, output xdata_t rdata);
        apb_transfer(1'b0, addr, '0, rdata);
    endtask

    // cycles counts clock edges since the APB write that changed the reset register
    task automatic wait_core_rst_n(input logic level, output int cycles);
        cycles = 1;
        @(negedge clk);
        while (core_rst_n !== level && cycles < RST_TMO) begin
            @(negedge clk);
            cycles++;
        end
        if (core_rst_n !== level) begin
            tmo_cnt++;
            $display("timeout: core_rst_n did not go to %b within %0d cycles", level, RST_TMO);
        end
    endtask

    // one request per cycle and each result is due exactly one cycle after its strobe
    task automatic drive_requests(input logic core_on);
        mem_req_t sent;
        mem_req_t exp;
        logic     in_win;
        int       i;
        for (i = 0; i <= stim_q.size(); i++) begin
            @(posedge clk);
            if (i < stim_q.size()) begin
                core_req_valid <= 1'b1;
                core_req       <= stim_q[i];
            end else begin
                core_req_valid <= 1'b0;
                core_req       <= '0;
            end
            @(negedge clk);
            if (i > 0) begin
                sent   = stim_q[i-1];
                in_win = sent.addr[`XLEN-1];
                exp    = mem_request(sent.we, sent.addr - `DRAM_BASE + cur_offset, sent.wdata);
                check_bit("ddr_req_valid", ddr_req_valid, core_on & in_win);
                check_bit("addr_err", addr_err, core_on & ~in_win);
                if (core_on && in_win) begin
                    check_req("ddr_req", ddr_req, exp);
                end
            end
        end
        stim_q.delete();
    endtask

    task automatic reset_values();
        logic [63:0] ver = `RISCV_VER;
        xdata_t      d;
        @(negedge clk);
        check_bit("core_rst_n", core_rst_n, 1'b0);
        check_bit("ddr_req_valid", ddr_req_valid, 1'b0);
        check_bit("addr_err", addr_err, 1'b0);
        apb_read(`CFGREG_RSTN, d);
        check_data("core reset register", d, '0);
        apb_read(`CFGREG_BOOTVEC, d);
        check_data("boot vector", d, '0);
        apb_read(`CFGREG_DDROFFSET, d);
        check_data("ddr offset", d, `DDR_OFFSET_RST);
        apb_read(`CFGREG_RSVREG0, d);
        check_data("scratch 0", d, '0);
        apb_read(`CFGREG_RSVREG1, d);
        check_data("scratch 1", d, '0);
        apb_read(`CFGREG_VER, d);
        check_data("version high", d, ver[63:32]);
        apb_read(`CFGREG_VER + 4, d);
        check_data("version low", d, ver[31:0]);
        apb_read(32'h0000_0100, d);
        check_data("unmapped offset", d, '0);
    endtask

    task automatic register_readback();
        logic [63:0] ver = `RISCV_VER;
        xdata_t      d;
        xdata_t      r0;
        xdata_t      r1;
        cur_boot   = $random(seed);
        cur_offset = $random(seed);
        r0         = $random(seed);
        r1         = $random(seed);
        apb_write(`CFGREG_BOOTVEC, cur_boot);
        apb_write(`CFGREG_DDROFFSET, cur_offset);
        apb_write(`CFGREG_RSVREG0, r0);
        apb_write(`CFGREG_RSVREG1, r1);
        apb_read(`CFGREG_BOOTVEC, d);
        check_data("boot vector readback", d, cur_boot);
        apb_read(`CFGREG_DDROFFSET, d);
        check_data("ddr offset readback", d, cur_offset);
        apb_read(`CFGREG_RSVREG0, d);
        check_data("scratch 0 readback", d, r0);
        apb_read(`CFGREG_RSVREG1, d);
        check_data("scratch 1 readback", d, r1);
        apb_write(`CFGREG_VER, $random(seed));  // the version is read-only and ignores the write
        apb_write(`CFGREG_VER + 4, $random(seed));
        apb_read(`CFGREG_VER, d);
        check_data("version high after write", d, ver[63:32]);
        apb_read(`CFGREG_VER + 4, d);
        check_data("version low after write", d, ver[31:0]);
    endtask

    task automatic core_release();
        xaddr_t old_boot;
        xdata_t d;
        int     cycles;
        apb_write(`CFGREG_RSTN, 32'h1);
        wait_core_rst_n(1'b1, cycles);
        check_data("core_rst_n release delay", xdata_t'(cycles), `CORE_RST_HOLD + 1);
        check_addr("boot_addr", boot_addr, cur_boot);
        // the running core keeps the boot address it was released with
        old_boot = cur_boot;
        cur_boot = $random(seed);
        apb_write(`CFGREG_BOOTVEC, cur_boot);
        @(negedge clk);
        check_addr("boot_addr after boot vector write", boot_addr, old_boot);
        apb_read(`CFGREG_RSTN, d);
        check_data("core reset register", d, 32'h1);
    endtask

    task automatic dram_remap();
        xdata_t r;
        int     i;
        r = $random(seed);
        stim_q.push_back(mem_request(1'b1, {1'b1, r[30:0]}, $random(seed)));
        drive_requests(1'b1);
        for (i = 0; i < 4; i++) begin
            r = $random(seed);
            stim_q.push_back(mem_request(r[0], {1'b1, r[31:1]}, $random(seed)));
        end
        drive_requests(1'b1);
        cur_offset = $random(seed);
        apb_write(`CFGREG_DDROFFSET, cur_offset);
        stim_q.push_back(mem_request(1'b0, `DRAM_BASE, $random(seed)));  // first window word
        stim_q.push_back(mem_request(1'b1, 32'hFFFF_FFFC, $random(seed)));
        drive_requests(1'b1);
    endtask

    task automatic window_errors();
        xdata_t r;
        r = $random(seed);
        stim_q.push_back(mem_request(1'b1, 32'h7FFF_FFFC, $random(seed)));
        stim_q.push_back(mem_request(1'b0, {1'b1, r[30:0]}, $random(seed)));
        stim_q.push_back(mem_request(1'b0, {1'b0, r[30:0]}, $random(seed)));
        stim_q.push_back(mem_request(1'b1, 32'h0000_0000, $random(seed)));
        drive_requests(1'b1);
    endtask

    task automatic requests_in_reset();
        xdata_t r;
        int     cycles;
        apb_write(`CFGREG_RSTN, 32'h0);
        wait_core_rst_n(1'b0, cycles);
        check_data("core_rst_n assert delay", xdata_t'(cycles), 1);
        r = $random(seed);
        stim_q.push_back(mem_request(1'b1, {1'b1, r[30:0]}, $random(seed)));
        stim_q.push_back(mem_request(1'b0, {1'b0, r[30:0]}, $random(seed)));
        drive_requests(1'b0);
        // the hold count keeps requests out as well
        apb_write(`CFGREG_RSTN, 32'h1);
        stim_q.push_back(mem_request(1'b1, {1'b1, r[31:1]}, $random(seed)));
        stim_q.push_back(mem_request(1'b1, {1'b0, r[31:1]}, $random(seed)));
        drive_requests(1'b0);
        wait_core_rst_n(1'b1, cycles);
        check_addr("boot_addr after second release", boot_addr, cur_boot);
        stim_q.push_back(mem_request(1'b0, {1'b1, r[30:0]}, $random(seed)));
        drive_requests(1'b1);
    endtask

    initial begin
        rstn           = 1'b0;
        apb_req        = '0;
        core_req_valid = 1'b0;
        core_req       = '0;
        cur_boot       = '0;
        cur_offset     = `DDR_OFFSET_RST;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        reset_values();
        register_readback();
        core_release();
        dram_remap();
        window_errors();
        requests_in_reset();
        $display("errors: %0d value mismatches, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* hdl/cfg_subsys.sv */
module cfg_subsys (
    input  logic              clk,
    input  logic              rstn,
    input  cfg_pkg::apb_req_t apb_req,
    output cfg_pkg::apb_rsp_t apb_rsp,
    input  logic              core_req_valid,
    input  cfg_pkg::mem_req_t core_req,
    output logic              core_rst_n,
    output cfg_pkg::xaddr_t   boot_addr,
    output logic              ddr_req_valid,
    output cfg_pkg::mem_req_t ddr_req,
    output logic              addr_err
);

    import cfg_pkg::*;

    xaddr_t boot_vec;
    xaddr_t ddr_offset;
    logic   core_rstn_req;

    cfgreg u_cfgreg (
        .clk           (clk),
        .rstn          (rstn),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .boot_vec      (boot_vec),
        .ddr_offset    (ddr_offset),
        .core_rstn_req (core_rstn_req)
    );

    core_rst_seq u_core_rst_seq (
        .clk           (clk),
        .rstn          (rstn),
        .core_rstn_req (core_rstn_req),
        .boot_vec      (boot_vec),
        .core_rst_n    (core_rst_n),
        .boot_addr     (boot_addr)
    );

    // the remapper watches the sequenced reset, not the raw register bit
    ddr_remap u_ddr_remap (
        .clk            (clk),
        .rstn           (rstn),
        .core_rst_n     (core_rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .ddr_offset     (ddr_offset),
        .ddr_req_valid  (ddr_req_valid),
        .ddr_req        (ddr_req),
        .addr_err       (addr_err)
    );

endmodule

/* hdl/ddr_remap.sv */
`include "cfg_defs.svh"

module ddr_remap (
    input  logic              clk,
    input  logic              rstn,
    input  logic              core_rst_n,
    input  logic              core_req_valid,
    input  cfg_pkg::mem_req_t core_req,
    input  cfg_pkg::xaddr_t   ddr_offset,
    output logic              ddr_req_valid,
    output cfg_pkg::mem_req_t ddr_req,
    output logic              addr_err
);

    import cfg_pkg::*;

    logic   accept;
    logic   in_window;
    xaddr_t win_ofs;
    xaddr_t ddr_addr;

    // requests from a core held in reset are dropped silently
    assign accept    = core_req_valid & core_rst_n;
    assign in_window = core_req.addr >= xaddr_t'(`DRAM_BASE);
    assign win_ofs   = core_req.addr - xaddr_t'(`DRAM_BASE);
    assign ddr_addr  = win_ofs + ddr_offset;  // wraps at XLEN bits

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ddr_req_valid <= 1'b0;
            addr_err      <= 1'b0;
        end else begin
            ddr_req_valid <= accept & in_window;
            addr_err      <= accept & ~in_window;
        end
    end

    // a new request can be taken every cycle and this stage always holds the latest one
    always_ff @(posedge clk) begin
        if (accept && in_window) begin
            ddr_req <= '{we: core_req.we, addr: ddr_addr, wdata: core_req.wdata};
        end
    end

    a_one_result: assert property (@(posedge clk) disable iff (!rstn)
        !(ddr_req_valid && addr_err))
        else $error("ddr_remap: remapped request and address error in the same cycle");

endmodule

/* hdl/core_rst_seq.sv */
`include "cfg_defs.svh"

module core_rst_seq (
    input  logic            clk,
    input  logic            rstn,
    input  logic            core_rstn_req,
    input  cfg_pkg::xaddr_t boot_vec,
    output logic            core_rst_n,
    output cfg_pkg::xaddr_t boot_addr
);

    import cfg_pkg::*;

    localparam int unsigned CNT_W = $clog2(`CORE_RST_HOLD + 1);

    rst_state_t       state;
    rst_state_t       state_nxt;
    logic [CNT_W-1:0] cnt;

    always_comb begin
        state_nxt = state;
        case (state)
            HELD:    if (core_rstn_req) state_nxt = COUNT;
            COUNT: begin
                if (!core_rstn_req) begin
                    state_nxt = HELD;  // release withdrawn before the hold expired
                end else if (cnt == '0) begin
                    state_nxt = RUN;
                end
            end
            RUN:     if (!core_rstn_req) state_nxt = HELD;
            default: state_nxt = HELD;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= HELD;
            cnt        <= '0;
            core_rst_n <= 1'b0;
        end else begin
            state      <= state_nxt;
            core_rst_n <= (state_nxt == RUN);
            // one cycle is spent entering COUNT, so load one less than the hold
            if (state == HELD) begin
                cnt <= CNT_W'(`CORE_RST_HOLD - 1);
            end else if (state == COUNT && cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // sampled once per release so a later boot_vec write cannot move a running core
    always_ff @(posedge clk) begin
        if (state == COUNT && state_nxt == RUN) begin
            boot_addr <= boot_vec;
        end
    end

    a_release_held: assert property (@(posedge clk) disable iff (!rstn)
        $rose(core_rst_n) |-> $past(core_rstn_req) && $past(core_rstn_req, `CORE_RST_HOLD + 1))
        else $error("core_rst_seq: core released without a held reset request");

endmodule

/* hdl/cfgreg.sv */
`include "cfg_defs.svh"

module cfgreg #(
    parameter logic [63:0] VERSION = `RISCV_VER
) (
    input  logic              clk,
    input  logic              rstn,
    input  cfg_pkg::apb_req_t apb_req,
    output cfg_pkg::apb_rsp_t apb_rsp,
    output cfg_pkg::xaddr_t   boot_vec,
    output cfg_pkg::xaddr_t   ddr_offset,
    output logic              core_rstn_req
);

    import cfg_pkg::*;

    localparam int unsigned OFS_W = 12;

    xdata_t           rsv_reg0;
    xdata_t           rsv_reg1;
    xdata_t           rdata;
    xdata_t           prdata_q;
    logic [OFS_W-1:0] ofs;
    logic             setup;
    logic             apb_wr;
    logic             apb_rd;

    assign ofs    = apb_req.paddr[OFS_W-1:0];  // upper address bits select the slave upstream
    assign setup  = apb_req.psel & ~apb_req.penable;
    assign apb_wr = setup & apb_req.pwrite;
    assign apb_rd = setup & ~apb_req.pwrite;

    // only bit 0 of the written word is kept
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            core_rstn_req <= 1'b0;
        end else if (apb_wr && ofs == `CFGREG_RSTN) begin
            core_rstn_req <= apb_req.pwdata[0];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            boot_vec <= '0;
        end else if (apb_wr && ofs == `CFGREG_BOOTVEC) begin
            boot_vec <= apb_req.pwdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ddr_offset <= xaddr_t'(`DDR_OFFSET_RST);
        end else if (apb_wr && ofs == `CFGREG_DDROFFSET) begin
            ddr_offset <= apb_req.pwdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rsv_reg0 <= '0;
        end else if (apb_wr && ofs == `CFGREG_RSVREG0) begin
            rsv_reg0 <= apb_req.pwdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rsv_reg1 <= '0;
        end else if (apb_wr && ofs == `CFGREG_RSVREG1) begin
            rsv_reg1 <= apb_req.pwdata;
        end
    end

    always_comb begin
        rdata = '0;
        case (ofs)
            `CFGREG_RSTN:         rdata = xdata_t'(core_rstn_req);
            `CFGREG_BOOTVEC:      rdata = boot_vec;
            `CFGREG_DDROFFSET:    rdata = ddr_offset;
            `CFGREG_RSVREG0:      rdata = rsv_reg0;
            `CFGREG_RSVREG1:      rdata = rsv_reg1;
            `CFGREG_VER:          rdata = VERSION[63:32];
            `CFGREG_VER + 12'h4:  rdata = VERSION[31:0];
            default:              rdata = '0;  // unmapped offsets read as zero
        endcase
    end

    // captured at the end of the setup phase and held through the access phase
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prdata_q <= '0;
        end else if (apb_rd) begin
            prdata_q <= rdata;
        end
    end

    assign apb_rsp = '{prdata: prdata_q, pready: 1'b1, pslverr: 1'b0};

    a_access_phase: assert property (@(posedge clk) disable iff (!rstn)
        apb_req.psel && apb_req.penable |-> $past(setup) && !apb_rsp.pslverr)
        else $error("cfgreg: access phase without a setup phase or with an error response");

endmodule

/* hdl/cfg_pkg.sv */
`include "cfg_defs.svh"

package cfg_pkg;

    typedef logic [`XLEN-1:0] xaddr_t;
    typedef logic [`XLEN-1:0] xdata_t;

    // host to slave half of an APB transfer
    typedef struct packed {
        logic   psel;
        logic   penable;
        logic   pwrite;
        xaddr_t paddr;
        xdata_t pwdata;
    } apb_req_t;

    typedef struct packed {
        xdata_t prdata;
        logic   pready;
        logic   pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic   we;
        xaddr_t addr;
        xdata_t wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        HELD,
        COUNT,
        RUN
    } rst_state_t;

endpackage

/* cfg_defs.svh */
`ifndef CFG_DEFS_SVH
`define CFG_DEFS_SVH

`define XLEN             32

// offsets inside the 4 KiB configuration window
`define CFGREG_RSTN      12'h000
`define CFGREG_BOOTVEC   12'h004
`define CFGREG_DDROFFSET 12'h008
`define CFGREG_RSVREG0   12'h00C
`define CFGREG_RSVREG1   12'h010
`define CFGREG_VER       12'h020  // high word here, low word at the next offset

`define RISCV_VER        64'h5256_3332_0001_0003
`define DDR_OFFSET_RST   32'h2000_0000
`define DRAM_BASE        32'h8000_0000
`define CORE_RST_HOLD    8

`endif
